//--- design/blk_mem_params.svh
/* Block memory subsystem size parameters
   Word address, word and byte-lane widths */
`ifndef BLK_MEM_PARAMS_SVH
`define BLK_MEM_PARAMS_SVH

// 256-word memory
`define BLK_ADDR_W 8
`define BLK_DATA_W 32
`define BLK_LANE_W 8

`endif

//--- design/blk_mem_pkg.sv
/* Block memory shared types
   Addresses, words, byte enables and the engine command */
`default_nettype none

`include "blk_mem_params.svh"

package blk_mem_pkg;

   typedef logic [`BLK_ADDR_W-1:0] addr_t;
   typedef logic [`BLK_DATA_W-1:0] word_t;
   typedef logic [`BLK_LANE_W-1:0] lane_t;

   // One enable bit per byte lane
   typedef logic [`BLK_DATA_W/`BLK_LANE_W-1:0] be_t;

   typedef enum logic {
      CMD_COPY = 1'b0,
      CMD_SUM  = 1'b1
   } blk_cmd_t;

endpackage

`default_nettype wire

//--- design/ram_dp.sv
/* Single byte-lane column of the dual-port RAM
   Read-first on both ports, registered outputs */
`timescale 1ns/1ps
`default_nettype none

`include "blk_mem_params.svh"

module ram_dp (
   input  wire                 clk_i,

   // Port A
   input  wire                 enA_i,
   input  wire                 weA_i,
   input  wire blk_mem_pkg::addr_t addrA_i,
   input  wire blk_mem_pkg::lane_t dA_i,
   output blk_mem_pkg::lane_t  dA_o,

   // Port B
   input  wire                 enB_i,
   input  wire                 weB_i,
   input  wire blk_mem_pkg::addr_t addrB_i,
   input  wire blk_mem_pkg::lane_t dB_i,
   output blk_mem_pkg::lane_t  dB_o
);
   import blk_mem_pkg::*;

   lane_t mem [0:(2**`BLK_ADDR_W)-1];

   // Both ports in one process; same-address collisions are undefined
   always_ff @(posedge clk_i) begin
      if (enA_i) begin
         if (weA_i) begin
            mem[addrA_i] <= dA_i;
         end
         dA_o <= mem[addrA_i];
      end
      if (enB_i) begin
         if (weB_i) begin
            mem[addrB_i] <= dB_i;
         end
         dB_o <= mem[addrB_i];
      end
   end

endmodule

`default_nettype wire

//--- design/ram_dp_be.sv
/* Dual-port RAM with per-byte write enables
   Built from one ram_dp column per byte lane */
`timescale 1ns/1ps
`default_nettype none

`include "blk_mem_params.svh"

module ram_dp_be (
   input  wire                     clk_i,

   // Port A
   input  wire                     enA_i,
   input  wire blk_mem_pkg::be_t   weA_i,
   input  wire blk_mem_pkg::addr_t addrA_i,
   input  wire blk_mem_pkg::word_t dA_i,
   output wire blk_mem_pkg::word_t dA_o,

   // Port B
   input  wire                     enB_i,
   input  wire blk_mem_pkg::be_t   weB_i,
   input  wire blk_mem_pkg::addr_t addrB_i,
   input  wire blk_mem_pkg::word_t dB_i,
   output wire blk_mem_pkg::word_t dB_o
);

   localparam int num_lanes = `BLK_DATA_W / `BLK_LANE_W;

   // Each column sees its own enable bit, so partial writes need no merge
   for (genvar lane = 0; lane < num_lanes; lane++) begin : g_lane
      ram_dp ram_dp_inst (
         .clk_i   (clk_i),

         .enA_i   (enA_i),
         .weA_i   (weA_i[lane]),
         .addrA_i (addrA_i),
         .dA_i    (dA_i[lane*`BLK_LANE_W +: `BLK_LANE_W]),
         .dA_o    (dA_o[lane*`BLK_LANE_W +: `BLK_LANE_W]),

         .enB_i   (enB_i),
         .weB_i   (weB_i[lane]),
         .addrB_i (addrB_i),
         .dB_i    (dB_i[lane*`BLK_LANE_W +: `BLK_LANE_W]),
         .dB_o    (dB_o[lane*`BLK_LANE_W +: `BLK_LANE_W])
      );
   end

endmodule

`default_nettype wire

//--- design/blk_engine_ctrl.sv
/* Block engine control FSM
   Runs COPY and SUM commands over a word range on RAM port B */
`timescale 1ns/1ps
`default_nettype none

`include "blk_mem_params.svh"

module blk_engine_ctrl (
   input  wire                          clk_i,
   input  wire                          rst_i,

   input  wire                          cmd_start_i,
   input  wire blk_mem_pkg::blk_cmd_t   cmd_op_i,
   input  wire blk_mem_pkg::addr_t      cmd_src_i,
   input  wire blk_mem_pkg::addr_t      cmd_dst_i,
   input  wire [`BLK_ADDR_W:0]          cmd_len_i,

   output logic                         busy_o,
   output logic                         done_o,

   output logic                         ram_en_o,
   output blk_mem_pkg::be_t             ram_we_o,
   output blk_mem_pkg::addr_t           ram_addr_o,
   output blk_mem_pkg::word_t           ram_wdata_o,
   input  wire blk_mem_pkg::word_t      ram_rdata_i,

   output logic                         acc_clear_o,
   output logic                         acc_add_o
);
   import blk_mem_pkg::*;

   typedef enum logic [2:0] {
      IDLE, COPY_RD, COPY_WR, SUM_RD, SUM_DRAIN, DONE
   } state_t;

   localparam logic [`BLK_ADDR_W:0] one_word = 1;

   state_t              state;
   addr_t               src_ptr;
   addr_t               dst_ptr;
   logic [`BLK_ADDR_W:0] count;
   logic                start_ok;
   logic                rd_pending;

   // Starts are only taken from IDLE
   assign start_ok = cmd_start_i && (state == IDLE);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state      <= IDLE;
         rd_pending <= 1'b0;
      end else begin
         // Accumulator strobe trails each SUM read by one cycle
         rd_pending <= (state == SUM_RD);
         case (state)
            IDLE: begin
               if (start_ok) begin
                  if (cmd_len_i == '0) begin
                     state <= DONE;
                  end else if (cmd_op_i == CMD_SUM) begin
                     state <= SUM_RD;
                  end else begin
                     state <= COPY_RD;
                  end
               end
            end
            COPY_RD:   state <= COPY_WR;
            COPY_WR:   state <= (count == one_word) ? DONE : COPY_RD;
            SUM_RD:    state <= (count == one_word) ? SUM_DRAIN : SUM_RD;
            SUM_DRAIN: state <= DONE;
            DONE:      state <= IDLE;
            default:   state <= IDLE;
         endcase
      end
   end

   // Pointers and count
   always_ff @(posedge clk_i) begin
      if (start_ok) begin
         src_ptr <= cmd_src_i;
         dst_ptr <= cmd_dst_i;
         count   <= cmd_len_i;
      end else begin
         case (state)
            COPY_RD: src_ptr <= src_ptr + addr_t'(1);
            COPY_WR: begin
               dst_ptr <= dst_ptr + addr_t'(1);
               count   <= count - one_word;
            end
            SUM_RD: begin
               src_ptr <= src_ptr + addr_t'(1);
               count   <= count - one_word;
            end
            default: ;
         endcase
      end
   end

   assign busy_o      = (state != IDLE);
   assign done_o      = (state == DONE);
   assign ram_en_o    = (state == COPY_RD) || (state == COPY_WR) || (state == SUM_RD);
   assign ram_we_o    = (state == COPY_WR) ? '1 : '0;
   assign ram_addr_o  = (state == COPY_WR) ? dst_ptr : src_ptr;
   // Word read in COPY_RD is still on the RAM output during COPY_WR
   assign ram_wdata_o = ram_rdata_i;
   assign acc_clear_o = start_ok && (cmd_op_i == CMD_SUM);
   assign acc_add_o   = rd_pending;

endmodule

`default_nettype wire

//--- design/sum_accum.sv
/* Running total for the SUM command
   Wraps modulo 2 to the word width */
`timescale 1ns/1ps
`default_nettype none

`include "blk_mem_params.svh"

module sum_accum (
   input  wire                     clk_i,
   input  wire                     rst_i,
   input  wire                     clear_i,
   input  wire                     add_i,
   input  wire blk_mem_pkg::word_t data_i,
   output blk_mem_pkg::word_t      sum_o
);

   always_ff @(posedge clk_i) begin
      if (rst_i || clear_i) begin
         sum_o <= '0;
      end else if (add_i) begin
         // Carry out of the top bit is dropped
         sum_o <= sum_o + data_i;
      end
   end

endmodule

`default_nettype wire

//--- design/blk_mem_top.sv
/* Block memory subsystem top level
   Host on RAM port A, block engine on RAM port B */
`timescale 1ns/1ps
`default_nettype none

`include "blk_mem_params.svh"

module blk_mem_top (
   input  wire                        clk_i,
   input  wire                        rst_i,

   // Host port
   input  wire                        host_en_i,
   input  wire blk_mem_pkg::be_t      host_we_i,
   input  wire blk_mem_pkg::addr_t    host_addr_i,
   input  wire blk_mem_pkg::word_t    host_wdata_i,
   output wire blk_mem_pkg::word_t    host_rdata_o,

   // Engine command and status
   input  wire                        cmd_start_i,
   input  wire blk_mem_pkg::blk_cmd_t cmd_op_i,
   input  wire blk_mem_pkg::addr_t    cmd_src_i,
   input  wire blk_mem_pkg::addr_t    cmd_dst_i,
   input  wire [`BLK_ADDR_W:0]        cmd_len_i,
   output wire                        busy_o,
   output wire                        done_o,
   output wire blk_mem_pkg::word_t    sum_o
);
   import blk_mem_pkg::*;

   logic  ram_en_b;
   be_t   ram_we_b;
   addr_t ram_addr_b;
   word_t ram_wdata_b;
   word_t ram_rdata_b;
   logic  acc_clear;
   logic  acc_add;

   ram_dp_be ram_dp_be_inst (
      .clk_i   (clk_i),
      .enA_i   (host_en_i),
      .weA_i   (host_we_i),
      .addrA_i (host_addr_i),
      .dA_i    (host_wdata_i),
      .dA_o    (host_rdata_o),
      .enB_i   (ram_en_b),
      .weB_i   (ram_we_b),
      .addrB_i (ram_addr_b),
      .dB_i    (ram_wdata_b),
      .dB_o    (ram_rdata_b)
   );

   blk_engine_ctrl blk_engine_ctrl_inst (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .cmd_start_i (cmd_start_i),
      .cmd_op_i    (cmd_op_i),
      .cmd_src_i   (cmd_src_i),
      .cmd_dst_i   (cmd_dst_i),
      .cmd_len_i   (cmd_len_i),
      .busy_o      (busy_o),
      .done_o      (done_o),
      .ram_en_o    (ram_en_b),
      .ram_we_o    (ram_we_b),
      .ram_addr_o  (ram_addr_b),
      .ram_wdata_o (ram_wdata_b),
      .ram_rdata_i (ram_rdata_b),
      .acc_clear_o (acc_clear),
      .acc_add_o   (acc_add)
   );

   sum_accum sum_accum_inst (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .clear_i (acc_clear),
      .add_i   (acc_add),
      .data_i  (ram_rdata_b),
      .sum_o   (sum_o)
   );

endmodule

`default_nettype wire

//--- dv/blk_mem_tb.sv
/* Block memory subsystem testbench
   Replays host and engine records from the stim file and checks the results */
`timescale 1ns/1ps
`default_nettype none

`include "blk_mem_params.svh"

module blk_mem_tb;
   import blk_mem_pkg::*;

   localparam int clk_half = 50;
   localparam int drive_delay = 5;
   localparam int cycles_per_record = 600;

   // Record opcodes
   localparam logic [31:0] op_write     = 32'h0;
   localparam logic [31:0] op_read      = 32'h1;
   localparam logic [31:0] op_write_chk = 32'h2;
   localparam logic [31:0] op_copy      = 32'h3;
   localparam logic [31:0] op_sum       = 32'h4;
   localparam logic [31:0] op_sum_busy  = 32'h5;

   logic                 clk_i;
   logic                 rst_i;
   logic                 host_en_i;
   be_t                  host_we_i;
   addr_t                host_addr_i;
   word_t                host_wdata_i;
   word_t                host_rdata_o;
   logic                 cmd_start_i;
   blk_cmd_t             cmd_op_i;
   addr_t                cmd_src_i;
   addr_t                cmd_dst_i;
   logic [`BLK_ADDR_W:0] cmd_len_i;
   logic                 busy_o;
   logic                 done_o;
   word_t                sum_o;

   logic [31:0] rec_op[$];
   logic [31:0] rec_a[$];
   logic [31:0] rec_b[$];
   logic [31:0] rec_len[$];
   logic [31:0] rec_data[$];
   logic [31:0] rec_exp[$];
   int          cycle_count;
   int          cycle_limit;

   blk_mem_top blk_mem_top_inst (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .host_en_i    (host_en_i),
      .host_we_i    (host_we_i),
      .host_addr_i  (host_addr_i),
      .host_wdata_i (host_wdata_i),
      .host_rdata_o (host_rdata_o),
      .cmd_start_i  (cmd_start_i),
      .cmd_op_i     (cmd_op_i),
      .cmd_src_i    (cmd_src_i),
      .cmd_dst_i    (cmd_dst_i),
      .cmd_len_i    (cmd_len_i),
      .busy_o       (busy_o),
      .done_o       (done_o),
      .sum_o        (sum_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #(clk_half) clk_i = ~clk_i;
   end

   task automatic report_failure(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1, "run stopped");
   endtask

   task automatic check_word(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      assert (got === exp) else begin
         report_failure($sformatf("FAIL %s got 0x%08h expected 0x%08h", name, got, exp));
      end
   endtask

   // Watchdog against an engine that never raises done_o
   always @(posedge clk_i) begin
      cycle_count = cycle_count + 1;
      if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
         report_failure($sformatf("Timeout: the engine never finished within %0d cycles",
                                  cycle_limit));
      end
   end

   task automatic step_cycle();
      @(posedge clk_i);
      #(drive_delay);
   endtask

   task automatic load_records();
      int          fd;
      int          n;
      string       line;
      logic [31:0] f[6];
      fd = $fopen("dv/blk_mem_stim.txt", "r");
      if (fd == 0) begin
         report_failure("Could not open the stim file dv/blk_mem_stim.txt");
      end
      while ($fgets(line, fd) > 0) begin
         n = $sscanf(line, "%h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5]);
         if (line.getc(0) != "#" && n == 6) begin
            rec_op.push_back(f[0]);
            rec_a.push_back(f[1]);
            rec_b.push_back(f[2]);
            rec_len.push_back(f[3]);
            rec_data.push_back(f[4]);
            rec_exp.push_back(f[5]);
         end else if (line.getc(0) != "#" && n > 0) begin
            report_failure($sformatf("Malformed stim record: %s", line));
         end
      end
      $fclose(fd);
   endtask

   // One port A access; the read data is valid one cycle after the enable
   task automatic host_access(input logic [31:0] addr, input logic [31:0] mask,
                              input logic [31:0] data);
      host_en_i    = 1'b1;
      host_we_i    = be_t'(mask);
      host_addr_i  = addr_t'(addr);
      host_wdata_i = word_t'(data);
      step_cycle();
      host_en_i    = 1'b0;
      host_we_i    = '0;
   endtask

   task automatic run_engine(input logic [31:0] op, input logic [31:0] src,
                             input logic [31:0] dst, input logic [31:0] len,
                             input logic [31:0] exp);
      int   cycles;
      int   expected_cycles;
      logic is_sum;
      is_sum = (op != op_copy);
      // COPY spends two cycles per word, SUM one plus a drain
      if (len == 0) expected_cycles = 1;
      else if (is_sum) expected_cycles = int'(len) + 2;
      else expected_cycles = 2 * int'(len) + 1;
      cycles      = 0;
      cmd_start_i = 1'b1;
      cmd_op_i    = is_sum ? CMD_SUM : CMD_COPY;
      cmd_src_i   = addr_t'(src);
      cmd_dst_i   = addr_t'(dst);
      cmd_len_i   = len[`BLK_ADDR_W:0];
      do begin
         step_cycle();
         cycles++;
         check_word("busy_o", 32'(busy_o), 32'h1);
         // Competing COPY pulse mid-run must be dropped
         cmd_start_i = (op == op_sum_busy) && (cycles == 2);
         if (cmd_start_i) cmd_op_i = CMD_COPY;
      end while (done_o !== 1'b1);
      cmd_start_i = 1'b0;
      check_word("done_o latency", 32'(cycles), 32'(expected_cycles));
      if (is_sum) check_word("sum_o", sum_o, exp);
      step_cycle();
      check_word("done_o", 32'(done_o), 32'h0);
      check_word("busy_o", 32'(busy_o), 32'h0);
   endtask

   initial begin
      rst_i        = 1'b1;
      host_en_i    = 1'b0;
      host_we_i    = '0;
      host_addr_i  = '0;
      host_wdata_i = '0;
      cmd_start_i  = 1'b0;
      cmd_op_i     = CMD_COPY;
      cmd_src_i    = '0;
      cmd_dst_i    = '0;
      cmd_len_i    = '0;
      cycle_count  = 0;
      cycle_limit  = 0;
      load_records();
      if (rec_op.size() == 0) report_failure("The stim file holds no records");
      cycle_limit = rec_op.size() * cycles_per_record;
      repeat (3) step_cycle();
      rst_i = 1'b0;
      check_word("busy_o", 32'(busy_o), 32'h0);
      check_word("done_o", 32'(done_o), 32'h0);
      check_word("sum_o", sum_o, 32'h0);
      foreach (rec_op[i]) begin
         case (rec_op[i])
            op_write: host_access(rec_a[i], rec_b[i], rec_data[i]);
            op_read, op_write_chk: begin
               host_access(rec_a[i], (rec_op[i] == op_read) ? 32'h0 : rec_b[i], rec_data[i]);
               check_word("host_rdata_o", host_rdata_o, rec_exp[i]);
            end
            op_copy, op_sum, op_sum_busy: begin
               run_engine(rec_op[i], rec_a[i], rec_b[i], rec_len[i], rec_exp[i]);
            end
            default: report_failure($sformatf("Unknown opcode %0h in record %0d", rec_op[i], i));
         endcase
      end
      $display("Simulation passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- dv/blk_mem_stim.txt
# op addr b len data expected, all hex; b is the byte mask for writes, the dst for copy
# op 0 write, 1 read, 2 write with old-word check, 3 copy, 4 sum, 5 sum with copy start while busy
0 10 f 0 11111111 0
0 11 f 0 22222222 0
0 12 f 0 33333333 0
0 13 f 0 44444444 0
0 14 f 0 80000000 0
0 15 f 0 90000001 0
0 20 f 0 aabbccdd 0
0 20 5 0 11223344 0
0 20 8 0 99000000 0
1 20 0 0 0 9922cc44
2 20 3 0 00005566 9922cc44
1 20 0 0 0 99225566
0 30 f 0 0badf00d 0
0 34 f 0 5a5a5a5a 0
3 10 31 3 0 0
1 30 0 0 0 0badf00d
1 31 0 0 0 11111111
1 33 0 0 0 33333333
1 34 0 0 0 5a5a5a5a
0 40 f 0 01020304 0
0 41 f 0 05060708 0
0 42 f 0 0a0b0c0d 0
3 40 41 2 0 0
1 41 0 0 0 01020304
1 42 0 0 0 01020304
4 10 0 6 0 baaaaaab
4 10 0 0 0 00000000
4 14 0 1 0 80000000
5 13 30 3 0 54444445
1 30 0 0 0 0badf00d
1 32 0 0 0 22222222

//--- verilog.f
+incdir+design
design/blk_mem_pkg.sv
design/ram_dp.sv
design/ram_dp_be.sv
design/blk_engine_ctrl.sv
design/sum_accum.sv
design/blk_mem_top.sv
dv/blk_mem_tb.sv

//--- Makefile
# Verilator build for the block memory subsystem
VERILATOR  ?= verilator
TOP        ?= blk_mem_tb
FILELIST   ?= verilog.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
SIM_FLAGS  ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "sim: FAIL"; exit 1; fi
	@grep -q "Simulation passed" $(LOG) || { echo "sim: no result in log"; exit 1; }
	@echo "sim: PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
